// ==== common/vga_pkg.sv ====
package vga_pkg;

	// horizontal raster in pixels
	localparam int h_active = 640;
	localparam int h_front  = 16;
	localparam int h_sync   = 96;
	localparam int h_back   = 48;
	localparam int h_total  = h_active + h_front + h_sync + h_back; // 800

	// vertical raster in lines
	localparam int v_active = 480;
	localparam int v_front  = 10;
	localparam int v_sync   = 2;
	localparam int v_back   = 33;
	localparam int v_total  = v_active + v_front + v_sync + v_back; // 525

	localparam int hs_start = h_active + h_front;
	localparam int hs_end   = hs_start + h_sync;
	localparam int vs_start = v_active + v_front;
	localparam int vs_end   = vs_start + v_sync;

	localparam logic sync_on = 1'b0; // both syncs active low

	// board geometry
	localparam int cell_w    = 80;
	localparam int cell_h    = 60;
	localparam int line_half = 2; // grid band is (edge-2, edge+2]
	localparam int ptr_half  = 5;

	// 12-bit rgb with 4 bits per channel
	localparam logic [11:0] col_black = 12'h000;
	localparam logic [11:0] col_white = 12'hfff;
	localparam logic [11:0] col_green = 12'h0f0;
	localparam logic [11:0] col_blue  = 12'h00f;
	localparam logic [11:0] col_red   = 12'hf00;
	localparam logic [11:0] col_bg    = 12'h555;
	localparam logic [11:0] col_line  = col_blue;
	localparam logic [11:0] col_ship  = col_blue;
	localparam logic [11:0] col_hit   = 12'he91;
	localparam logic [11:0] col_both  = 12'hf0f;

	localparam int render_lat = 2; // counters to rgb

endpackage

// ==== common/board_pkg.sv ====
package board_pkg;

	// one status word per cell
	localparam int stat_w = 4;

	// status bit positions
	localparam int st_ship   = 0; // ship in the cell
	localparam int st_shot_a = 1; // player fired here
	localparam int st_shot_b = 2; // opponent fired here
	localparam int st_sunk   = 3; // ship sunk

	// board layout
	localparam int board_cols = 8;
	localparam int board_rows = 8;
	localparam int cell_count = board_cols * board_rows;

	// address is row * 8 + col, so row in the upper half
	localparam int addr_w = 6;

endpackage

// ==== hw/scan_timing.sv ====
module scan_timing (
	input  logic       clk_in,
	input  logic       rst_n,
	output logic [9:0] pix_x,
	output logic [9:0] pix_y,
	output logic       active,
	output logic       hsync,
	output logic       vsync
);

	logic [9:0] h_next;
	logic [9:0] v_next;

	// next raster position wrapping at the frame end
	always_comb
	begin
		h_next = pix_x + 10'd1;
		v_next = pix_y;
		if (pix_x == 10'(vga_pkg::h_total - 1))
		begin
			h_next = 10'd0;
			if (pix_y == 10'(vga_pkg::v_total - 1))
				v_next = 10'd0;
			else
				v_next = pix_y + 10'd1;
		end
	end

	// flags are built from the next position so they line up with the counters
	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pix_x  <= 10'd0;
			pix_y  <= 10'd0;
			active <= 1'b1; // (0,0) is visible
			hsync  <= ~vga_pkg::sync_on;
			vsync  <= ~vga_pkg::sync_on;
		end
		else
		begin
			pix_x  <= h_next;
			pix_y  <= v_next;
			active <= (h_next < 10'(vga_pkg::h_active)) && (v_next < 10'(vga_pkg::v_active));
			if (h_next >= 10'(vga_pkg::hs_start) && h_next < 10'(vga_pkg::hs_end))
				hsync <= vga_pkg::sync_on;
			else
				hsync <= ~vga_pkg::sync_on;
			if (v_next >= 10'(vga_pkg::vs_start) && v_next < 10'(vga_pkg::vs_end))
				vsync <= vga_pkg::sync_on;
			else
				vsync <= ~vga_pkg::sync_on;
		end
	end

endmodule

// ==== board_ram/board_ram.sv ====
module board_ram (
	input  logic                         clk_in,
	input  logic                         rst_n,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [board_pkg::addr_w-1:0] wb_adr,
	input  logic [board_pkg::stat_w-1:0] wb_dat_w,
	output logic [board_pkg::stat_w-1:0] wb_dat_r,
	output logic                         wb_ack,
	input  logic [board_pkg::addr_w-1:0] rd_adr,
	output logic [board_pkg::stat_w-1:0] rd_stat
);

	logic [board_pkg::stat_w-1:0] mem [board_pkg::cell_count];
	logic                         wb_go;

	// ack drops between accesses so each access gets a single pulse
	assign wb_go = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < board_pkg::cell_count; i++)
				mem[i] <= '0; // empty board
			wb_ack  <= 1'b0;
			rd_stat <= '0;
		end
		else
		begin
			wb_ack  <= wb_go;
			rd_stat <= mem[rd_adr]; // old value if written on this edge
			if (wb_go && wb_we)
				mem[wb_adr] <= wb_dat_w;
		end
	end

	// host read data is valid while ack is high
	always_ff @(posedge clk_in)
	begin
		if (wb_go)
			wb_dat_r <= mem[wb_adr];
	end

endmodule

// ==== renderer/cell_locator.sv ====
module cell_locator (
	input  logic                         clk_in,
	input  logic                         rst_n,
	input  logic [9:0]                   pix_x,
	input  logic [9:0]                   pix_y,
	input  logic                         active,
	input  logic                         hsync,
	input  logic                         vsync,
	output logic [board_pkg::addr_w-1:0] rd_adr,
	output logic [6:0]                   off_u,
	output logic [5:0]                   off_v,
	output logic                         on_line,
	output logic [9:0]                   px_q,
	output logic [9:0]                   py_q,
	output logic                         active_q,
	output logic                         hsync_q,
	output logic                         vsync_q
);

	int col_i;
	int row_i;
	int u_c;
	int v_c;

	// index of the highest cell edge at or below pos
	function automatic int cell_of(input logic [9:0] pos, input int period, input int count);
		int idx;
		idx = 0;
		for (int k = 1; k < count; k++)
			if (int'(pos) >= k * period)
				idx = k;
		return idx;
	endfunction

	// inside one of the inner grid bands
	function automatic logic on_band(input logic [9:0] pos, input int period, input int count);
		logic hit;
		hit = 1'b0;
		for (int k = 1; k < count; k++)
			if (int'(pos) > k * period - vga_pkg::line_half &&
				int'(pos) <= k * period + vga_pkg::line_half)
				hit = 1'b1;
		return hit;
	endfunction

	always_comb
	begin
		col_i = cell_of(pix_x, vga_pkg::cell_w, board_pkg::board_cols);
		row_i = cell_of(pix_y, vga_pkg::cell_h, board_pkg::board_rows);
		u_c   = int'(pix_x) - col_i * vga_pkg::cell_w;
		v_c   = int'(pix_y) - row_i * vga_pkg::cell_h;
	end

	// the ram read register holds this stage's cell index
	assign rd_adr = {row_i[board_pkg::addr_w/2-1:0], col_i[board_pkg::addr_w/2-1:0]};

	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			off_u    <= '0;
			off_v    <= '0;
			on_line  <= 1'b0;
			px_q     <= '0;
			py_q     <= '0;
			active_q <= 1'b0;
			hsync_q  <= ~vga_pkg::sync_on;
			vsync_q  <= ~vga_pkg::sync_on;
		end
		else
		begin
			off_u    <= u_c[6:0]; // out of range only in blanking
			off_v    <= v_c[5:0];
			on_line  <= on_band(pix_x, vga_pkg::cell_w, board_pkg::board_cols) ||
				on_band(pix_y, vga_pkg::cell_h, board_pkg::board_rows);
			px_q     <= pix_x;
			py_q     <= pix_y;
			active_q <= active;
			hsync_q  <= hsync;
			vsync_q  <= vsync;
		end
	end

endmodule

// ==== renderer/pixel_renderer.sv ====
module pixel_renderer (
	input  logic                         clk_in,
	input  logic                         rst_n,
	input  logic [board_pkg::stat_w-1:0] rd_stat,
	input  logic [6:0]                   off_u,
	input  logic [5:0]                   off_v,
	input  logic                         on_line,
	input  logic [9:0]                   px_q,
	input  logic [9:0]                   py_q,
	input  logic                         active_q,
	input  logic                         hsync_q,
	input  logic                         vsync_q,
	input  logic [9:0]                   ptr_x,
	input  logic [9:0]                   ptr_y,
	output logic [11:0]                  rgb,
	output logic                         hsync,
	output logic                         vsync,
	output logic                         de
);

	int          u;
	int          v;
	int          du;
	int          dv;
	int          ring_r;
	logic        has_ship;
	logic        shot_a;
	logic        shot_b;
	logic        sunk;
	logic        in_ship;
	logic        in_cross;
	logic        in_ring;
	logic        in_glyph;
	logic        in_ptr;
	logic [11:0] cell_col;
	logic [11:0] pix_col;

	function automatic int iabs(input int a);
		return (a < 0) ? -a : a;
	endfunction

	assign has_ship = rd_stat[board_pkg::st_ship];
	assign shot_a   = rd_stat[board_pkg::st_shot_a];
	assign shot_b   = rd_stat[board_pkg::st_shot_b];
	assign sunk     = rd_stat[board_pkg::st_sunk];

	// glyph shapes in cell coordinates
	always_comb
	begin
		u        = int'(off_u);
		v        = int'(off_v);
		du       = iabs(u - 40); // distance from cell centre
		dv       = iabs(v - 30);
		ring_r   = (du > dv) ? du : dv;
		in_ship  = (u >= 10) && (u <= 69) && (v >= 22) && (v <= 37);
		in_cross = (iabs(u - v - 10) <= 1) || (iabs(u + v - 69) <= 1); // both diagonals
		in_ring  = (ring_r >= 16) && (ring_r <= 18); // square outline
		in_glyph = (has_ship && in_ship) || (shot_a && in_cross) || (shot_b && in_ring);
	end

	// cell colour from status
	always_comb
	begin
		if (rd_stat == '0)
			cell_col = vga_pkg::col_green;
		else if (!in_glyph)
			cell_col = vga_pkg::col_bg;
		else if (sunk)
			cell_col = vga_pkg::col_red;
		else if (has_ship && (shot_a || shot_b))
			cell_col = vga_pkg::col_both;
		else if (shot_a || shot_b)
			cell_col = vga_pkg::col_hit;
		else
			cell_col = vga_pkg::col_ship;
	end

	assign in_ptr = (iabs(int'(px_q) - int'(ptr_x)) <= vga_pkg::ptr_half) &&
		(iabs(int'(py_q) - int'(ptr_y)) <= vga_pkg::ptr_half);

	// pointer over grid over cell and black in blanking
	always_comb
	begin
		if (!active_q)
			pix_col = vga_pkg::col_black;
		else if (in_ptr)
			pix_col = vga_pkg::col_white;
		else if (on_line)
			pix_col = vga_pkg::col_line;
		else
			pix_col = cell_col;
	end

	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rgb   <= vga_pkg::col_black;
			hsync <= ~vga_pkg::sync_on;
			vsync <= ~vga_pkg::sync_on;
			de    <= 1'b0;
		end
		else
		begin
			rgb   <= pix_col;
			hsync <= hsync_q;
			vsync <= vsync_q;
			de    <= active_q;
		end
	end

endmodule

// ==== hw/battle_display.sv ====
module battle_display (
	input  logic                         clk_in,
	input  logic                         rst_n,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [board_pkg::addr_w-1:0] wb_adr,
	input  logic [board_pkg::stat_w-1:0] wb_dat_w,
	output logic [board_pkg::stat_w-1:0] wb_dat_r,
	output logic                         wb_ack,
	input  logic [9:0]                   ptr_x,
	input  logic [9:0]                   ptr_y,
	output logic [11:0]                  rgb,
	output logic                         hsync,
	output logic                         vsync,
	output logic                         de
);

	logic [9:0]                   pix_x;
	logic [9:0]                   pix_y;
	logic                         active;
	logic                         hs_raw;
	logic                         vs_raw;
	logic [board_pkg::addr_w-1:0] rd_adr;
	logic [board_pkg::stat_w-1:0] rd_stat;
	logic [6:0]                   off_u;
	logic [5:0]                   off_v;
	logic                         on_line;
	logic [9:0]                   px_q;
	logic [9:0]                   py_q;
	logic                         active_q;
	logic                         hsync_q;
	logic                         vsync_q;

	scan_timing u_scan (.clk_in(clk_in), .rst_n(rst_n), .pix_x(pix_x), .pix_y(pix_y),
		.active(active), .hsync(hs_raw), .vsync(vs_raw));

	board_ram u_ram (.clk_in(clk_in), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack), .rd_adr(rd_adr), .rd_stat(rd_stat));

	// stage 1 does the cell lookup alongside the ram read
	cell_locator u_loc (.clk_in(clk_in), .rst_n(rst_n), .pix_x(pix_x), .pix_y(pix_y),
		.active(active), .hsync(hs_raw), .vsync(vs_raw), .rd_adr(rd_adr), .off_u(off_u),
		.off_v(off_v), .on_line(on_line), .px_q(px_q), .py_q(py_q), .active_q(active_q),
		.hsync_q(hsync_q), .vsync_q(vsync_q));

	// stage 2 picks the colour
	pixel_renderer u_rend (.clk_in(clk_in), .rst_n(rst_n), .rd_stat(rd_stat),
		.off_u(off_u), .off_v(off_v), .on_line(on_line), .px_q(px_q), .py_q(py_q),
		.active_q(active_q), .hsync_q(hsync_q), .vsync_q(vsync_q), .ptr_x(ptr_x),
		.ptr_y(ptr_y), .rgb(rgb), .hsync(hsync), .vsync(vsync), .de(de));

endmodule

// ==== bench/tb_battle_display.sv ====
module tb_battle_display;

	localparam int frame_cyc   = 800 * 525;
	localparam int timeout_cyc = 3 * frame_cyc; // probes end inside frame 2
	localparam int n_rows      = 25;

	logic        clk_in;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [5:0]  wb_adr;
	logic [3:0]  wb_dat_w;
	logic [3:0]  wb_dat_r;
	logic        wb_ack;
	logic [9:0]  ptr_x;
	logic [9:0]  ptr_y;
	logic [11:0] rgb;
	logic        hsync;
	logic        vsync;
	logic        de;

	int          cyc;
	int          errs;
	int          n_tests;
	int          n_fail;
	int          mon_n;
	int          mon_err;
	int          mpos;
	int          mx;
	int          my;
	logic        exp_hs;
	logic        exp_vs;
	logic        exp_de;
	logic [3:0]  model [64];

	// frame, cell, status (-1 random), write first, x, y, ptr x, ptr y, colour (-1 model)
	int tbl [n_rows][9] = '{
		'{1,  0,  0, 0,  40,  30, 1000, 1000, 'h0f0}, // empty cell
		'{1,  0,  0, 0,  78,  30, 1000, 1000, 'h0f0}, // just left of the band
		'{1,  0, -1, 0,  79,  30, 1000, 1000, 'h00f},
		'{1,  1, -1, 0,  80,  30, 1000, 1000, 'h00f},
		'{1,  1, -1, 0,  83,  30, 1000, 1000, -1},
		'{1,  9,  1, 0, 120,  70, 1000, 1000, 'h555}, // ship cell, off the glyph
		'{1, 12,  2, 0, 350,  80, 1000, 1000, 'he91}, // cross arm
		'{1,  9,  1, 0, 120,  90, 1000, 1000, 'h00f},
		'{1,  9,  1, 0, 126,  90,  120,   90, 'h00f}, // one past the pointer
		'{1,  9,  1, 0, 115,  95,  120,   90, 'hfff}, // pointer corner on glyph
		'{1, 12,  2, 0, 340, 100, 1000, 1000, 'h555},
		'{1, 21,  3, 0, 405, 125, 1000, 1000, 'h555},
		'{1, 21,  3, 0, 415, 145, 1000, 1000, 'hf0f},
		'{1, 19,  4, 0, 280, 150, 1000, 1000, 'h555}, // ring centre
		'{1, 19,  4, 0, 297, 150, 1000, 1000, 'he91},
		'{1, 26, -1, 0, 160, 180, 1000, 1000, 'h00f}, // band crossing
		'{1, 26, -1, 0, 166, 180,  160,  180, 'h00f},
		'{1, 26, -1, 0, 165, 182,  160,  180, 'hfff}, // pointer edge on the band
		'{1, 26,  0, 0, 200, 185, 1000, 1000, 'h0f0}, // scanned before the write
		'{1, 26,  1, 1, 200, 210, 1000, 1000, 'h00f}, // written mid-scan
		'{1, 35, 13, 0, 245, 245, 1000, 1000, 'h555},
		'{1, 35, 13, 0, 280, 252, 1000, 1000, 'hf00}, // sunk ring
		'{1, 46, -1, 0, 520, 330, 1000, 1000, -1},
		'{2, 26, -1, 0, 200, 185, 1000, 1000, 'h555},
		'{2, 26, -1, 0, 200, 210, 1000, 1000, 'h00f}
	};

	battle_display DUT (.clk_in(clk_in), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack), .ptr_x(ptr_x), .ptr_y(ptr_y), .rgb(rgb), .hsync(hsync),
		.vsync(vsync), .de(de));

	always #2 clk_in = ~clk_in;

	function automatic int abs_int(input int a);
		return (a < 0) ? -a : a;
	endfunction

	// colour of one screen pixel for a given cell status and pointer
	function automatic logic [11:0] ref_colour(input int x, input int y, input int px,
		input int py, input logic [3:0] st);
		int   u;
		int   v;
		int   ring;
		logic on_grid;
		logic glyph;
		if (x >= 640 || y >= 480)
			return 12'h000;
		if (abs_int(x - px) <= 5 && abs_int(y - py) <= 5)
			return 12'hfff;
		on_grid = 1'b0;
		for (int k = 1; k < 8; k++)
			if ((x > 80 * k - 2 && x <= 80 * k + 2) || (y > 60 * k - 2 && y <= 60 * k + 2))
				on_grid = 1'b1;
		if (on_grid)
			return 12'h00f;
		if (st == 4'h0)
			return 12'h0f0;
		u     = x % 80;
		v     = y % 60;
		ring  = (abs_int(u - 40) > abs_int(v - 30)) ? abs_int(u - 40) : abs_int(v - 30);
		glyph = (st[0] && u >= 10 && u <= 69 && v >= 22 && v <= 37) ||
			(st[1] && (abs_int(u - v - 10) <= 1 || abs_int(u + v - 69) <= 1)) ||
			(st[2] && ring >= 16 && ring <= 18);
		if (!glyph)
			return 12'h555;
		if (st[3])
			return 12'hf00;
		if (st[0] && (st[1] || st[2]))
			return 12'hf0f;
		if (st[1] || st[2])
			return 12'he91;
		return 12'h00f;
	endfunction

	task automatic end_test(input string name, input int e_before);
		n_tests++;
		if (errs == e_before)
			$display("[ok]   %s", name);
		else
		begin
			n_fail++;
			$display("[fail] %s (%0d errors)", name, errs - e_before);
		end
	endtask

	// compare one value and count a mismatch against the running test
	task automatic check_val(input string sig, input logic [11:0] e, input logic [11:0] g);
		if (g !== e)
		begin
			errs++;
			$display("[ERROR] %s: expected 0x%h, got 0x%h", sig, e, g);
		end
	endtask

	// classic cycle with stb held until ack
	task automatic wb_access(input logic we, input int adr, input logic [3:0] dat,
		output logic [3:0] rdat);
		int n;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = 6'(adr);
		wb_dat_w = dat;
		n = 0;
		do
		begin
			@(posedge clk_in);
			#1;
			n++;
		end
		while (!wb_ack && n < 8);
		rdat   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		if (n != 1 || !wb_ack)
		begin
			errs++;
			$display("wishbone cell %0d: no ack exactly one cycle after stb (%0d cycles)", adr, n);
		end
		@(posedge clk_in);
		#1;
		check_val($sformatf("wb_ack after cell %0d", adr), 12'h0, 12'(wb_ack));
	endtask

	task automatic note_mon(input string sig, input logic [11:0] e, input logic [11:0] g);
		mon_err++;
		if (mon_err <= 8) // first few only
			$display("[ERROR] %s at (%0d,%0d): expected 0x%h, got 0x%h", sig, mx, my, e, g);
	endtask

	always @(posedge clk_in)
	begin
		if (rst_n)
			cyc <= cyc + 1;
		if (cyc >= timeout_cyc)
		begin
			$display("timeout: run still going after %0d cycles", cyc);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// rgb after edge n shows the pixel the counters held at n-2
	always @(negedge clk_in)
	begin
		if (rst_n && cyc >= 2)
		begin
			mpos   = (cyc - 2) % frame_cyc;
			mx     = mpos % 800;
			my     = mpos / 800;
			exp_hs = !(mx >= 656 && mx < 752);
			exp_vs = !(my >= 490 && my < 492);
			exp_de = (mx < 640) && (my < 480);
			mon_n++;
			if (hsync !== exp_hs)
				note_mon("hsync", 12'(exp_hs), 12'(hsync));
			if (vsync !== exp_vs)
				note_mon("vsync", 12'(exp_vs), 12'(vsync));
			if (de !== exp_de)
				note_mon("de", 12'(exp_de), 12'(de));
			if (!exp_de && rgb !== 12'h000)
				note_mon("rgb", 12'h000, rgb);
		end
	end

	initial
	begin
		logic [3:0]  rd;
		logic [11:0] exp_col;
		int          t;
		int          e0;
		clk_in   = 1'b0;
		rst_n    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		ptr_x    = 10'd1000; // off screen
		ptr_y    = 10'd1000;
		cyc      = 0;
		errs     = 0;
		n_tests  = 0;
		n_fail   = 0;
		mon_n    = 0;
		mon_err  = 0;
		void'($urandom(32'hcc7c_b176));
		repeat (2) @(posedge clk_in);
		#1;
		e0 = errs;
		check_val("rgb in reset", 12'h000, rgb);
		check_val("de in reset", 12'h0, 12'(de));
		check_val("hsync in reset", 12'h1, 12'(hsync));
		check_val("vsync in reset", 12'h1, 12'(vsync));
		check_val("wb_ack in reset", 12'h0, 12'(wb_ack));
		end_test("reset state", e0);
		rst_n = 1'b1;

		for (int i = 0; i < 64; i++)
			model[i] = 4'($urandom);
		for (int r = 0; r < n_rows; r++)
			if (tbl[r][3] == 0 && tbl[r][2] >= 0)
				model[tbl[r][1]] = 4'(tbl[r][2]);
		e0 = errs;
		for (int i = 0; i < 64; i++)
			wb_access(1'b1, i, model[i], rd);
		end_test("wishbone writes of 64 cells", e0);
		e0 = errs;
		for (int i = 0; i < 64; i++)
		begin
			wb_access(1'b0, i, 4'h0, rd);
			check_val($sformatf("wb_dat_r cell %0d", i), 12'(model[i]), 12'(rd));
		end
		end_test("wishbone readback of 64 cells", e0);

		for (int r = 0; r < n_rows; r++)
		begin
			e0    = errs;
			ptr_x = 10'(tbl[r][6]);
			ptr_y = 10'(tbl[r][7]);
			if (tbl[r][3] != 0)
			begin
				wb_access(1'b1, tbl[r][1], 4'(tbl[r][2]), rd);
				model[tbl[r][1]] = 4'(tbl[r][2]);
			end
			t = tbl[r][0] * frame_cyc + tbl[r][5] * 800 + tbl[r][4];
			if (cyc > t + 2)
			begin
				errs++;
				$display("row %0d: probe pixel was already scanned", r);
			end
			while (cyc < t + 2)
			begin
				@(posedge clk_in);
				#1;
			end
			if (tbl[r][8] >= 0)
				exp_col = 12'(tbl[r][8]);
			else
				exp_col = ref_colour(tbl[r][4], tbl[r][5], tbl[r][6], tbl[r][7],
					model[tbl[r][1]]);
			check_val($sformatf("rgb at (%0d,%0d)", tbl[r][4], tbl[r][5]), exp_col, rgb);
			end_test($sformatf("pixel (%0d,%0d) frame %0d", tbl[r][4], tbl[r][5], tbl[r][0]), e0);
		end

		e0   = errs;
		errs = errs + mon_err;
		end_test($sformatf("sync, de and blanking over %0d cycles", mon_n), e0);
		$display("tests: %0d, failed: %0d, errors: %0d", n_tests, n_fail, errs);
		if (n_fail == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
common/vga_pkg.sv
common/board_pkg.sv
hw/scan_timing.sv
board_ram/board_ram.sv
renderer/cell_locator.sv
renderer/pixel_renderer.sv
hw/battle_display.sv
bench/tb_battle_display.sv

// ==== Makefile ====
TOP = tb_battle_display

sim:
	verilator --binary -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
